// File: Bender.yml
package:
  name: soc_bus

sources:
  - source/soc_pkg.sv
  - source/bus_router.sv
  - source/bram.sv
  - source/uart_tx.sv
  - source/clint.sv
  - source/soc_bus.sv
  - target: test
    files:
      - dv/soc_bus_tb.sv

// File: dv/bus_cases.txt
# port addr wdata wstrb expected check (all numbers hex except check)
# port is i, d or b (both ports, same address); wstrb 0 reads; check 1 compares rdata
d 00000000 11223344 f 00000000 0
d 00000004 a5a5a5a5 f 00000000 0
d 00000000 00000000 0 11223344 1
d 00000004 00000000 0 a5a5a5a5 1
d 000003fc deadbeef f 00000000 0
i 000003fc 00000000 0 deadbeef 1
d 00000004 0000cc00 2 00000000 0
d 00000004 00000000 0 a5a5cca5 1
d 00000000 77000066 9 00000000 0
d 00000000 00000000 0 77223366 1
b 00000004 00000000 0 a5a5cca5 1
d 10000000 000000a5 1 00000000 0
d 10000004 00000000 0 00000001 1
d 10000000 0000003c 1 00000000 0
d 20000000 00000001 f 00000000 0
d 20000000 00000000 0 00000001 1
d 2000bff8 00000000 0 00000000 0
d 2000bff8 00000000 0 00000000 0
d 20004000 00000020 f 00000000 0
d 20004004 00000000 f 00000000 0
d 20004000 00000000 0 00000020 1
d 20004004 ffffffff f 00000000 0
d 20004004 00000000 0 ffffffff 1

// File: dv/soc_bus_tb.sv
`timescale 1ns/1ns

module soc_bus_tb;

  localparam int REQ_TIMEOUT = 200;
  localparam int MTIP_TIMEOUT = 100;
  localparam int FRAME_TIMEOUT = 400;

  logic              clk;
  logic              rst;
  soc_pkg::mem_req_t ibus_req;
  soc_pkg::mem_req_t dbus_req;
  soc_pkg::mem_rsp_t ibus_rsp;
  soc_pkg::mem_rsp_t dbus_rsp;
  logic              tx;
  logic              msip;
  logic              mtip;
  logic [63:0]       cyc_since_rst; // Tracks mtime, which counts from reset.
  logic [7:0]        tx_bytes [$];
  logic [7:0]        rx_bytes [$];
  logic              ops_done;

  soc_bus soc_bus_inst (
    .clk        (clk),
    .rst        (rst),
    .ibus_req_i (ibus_req),
    .dbus_req_i (dbus_req),
    .ibus_rsp_o (ibus_rsp),
    .dbus_rsp_o (dbus_rsp),
    .tx_o       (tx),
    .msip_o     (msip),
    .mtip_o     (mtip)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  always @(posedge clk) begin
    if (rst == 0) begin
      cyc_since_rst <= 64'd0;
    end else begin
      cyc_since_rst <= cyc_since_rst + 64'd1;
    end
  end

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] expected);
    if (got !== expected) begin
      $display("** Error: %s got 0x%0h, expected 0x%0h", name, got, expected);
      $display("TESTBENCH FAILED");
      $fatal(1, "Mismatch on %s.", name);
    end
  endtask

  task automatic report_failure(input string what);
    $display("Failure: %s.", what);
    $display("TESTBENCH FAILED");
    $fatal(1, "Run stopped.");
  endtask

  // Presents one request on one or both ports and holds each until its ready.
  task automatic issue_request(input logic use_i, input logic use_d,
                               input logic [31:0] addr, input logic [31:0] wdata,
                               input logic [3:0] wstrb,
                               output logic [31:0] i_data, output logic [31:0] d_data,
                               output int i_at, output int d_at);
    soc_pkg::mem_req_t req;
    logic i_done;
    logic d_done;
    logic i_hit;
    logic d_hit;
    int   cnt;
    req.valid = 1'b1;
    req.instr = 1'b0;
    req.addr = addr;
    req.wdata = wdata;
    req.wstrb = wstrb;
    i_done = !use_i;
    d_done = !use_d;
    i_data = '0;
    d_data = '0;
    i_at = 0;
    d_at = 0;
    cnt = 0;
    @(posedge clk);
    if (use_d) dbus_req <= req;
    req.instr = 1'b1;
    if (use_i) ibus_req <= req;
    while (!(i_done && d_done)) begin
      @(negedge clk);
      cnt++;
      if (cnt > REQ_TIMEOUT) report_failure("no ready came back for the bus request");
      i_hit = !i_done && ibus_rsp.ready;
      d_hit = !d_done && dbus_rsp.ready;
      if (i_hit) begin
        i_data = ibus_rsp.rdata;
        i_at = cnt;
        i_done = 1'b1;
      end
      if (d_hit) begin
        d_data = dbus_rsp.rdata;
        d_at = cnt;
        d_done = 1'b1;
      end
      @(posedge clk);
      if (i_hit) ibus_req <= '0;
      if (d_hit) dbus_req <= '0;
    end
  endtask

  // **************************************************
  // UART receiver that samples each bit in its middle.
  // **************************************************
  initial begin : uart_monitor
    logic       prev_tx;
    logic [7:0] rx;
    prev_tx = 1'b1;
    while (ops_done !== 1'b1) begin
      @(negedge clk);
      if (prev_tx && !tx) begin
        repeat (soc_pkg::UART_CLKS_PER_BIT / 2) @(negedge clk);
        check_value("tx_o start bit", tx, 0);
        for (int b = 0; b < 8; b++) begin
          repeat (soc_pkg::UART_CLKS_PER_BIT) @(negedge clk);
          rx[b] = tx;
        end
        repeat (soc_pkg::UART_CLKS_PER_BIT) @(negedge clk);
        check_value("tx_o stop bit", tx, 1);
        rx_bytes.push_back(rx);
      end
      prev_tx = tx;
    end
  end

  initial begin : main
    int          fd;
    int          n;
    int          check;
    int          cnt;
    int          i_at;
    int          d_at;
    logic [63:0] tok;
    logic [8*160-1:0] rest;
    logic [31:0] addr;
    logic [31:0] wdata;
    logic [31:0] expected;
    logic [3:0]  wstrb;
    logic [31:0] i_data;
    logic [31:0] d_data;
    logic        use_i;
    logic        use_d;
    logic [63:0] cmp_shadow;
    logic [31:0] last_mtime;
    logic        have_mtime;

    rst = 1'b0;
    ibus_req = '0;
    dbus_req = '0;
    ops_done = 1'b0;
    cmp_shadow = '1;
    have_mtime = 1'b0;
    repeat (8) @(posedge clk);
    rst <= 1'b1;
    @(negedge clk);
    check_value("tx_o", tx, 1);
    check_value("msip_o", msip, 0);
    check_value("mtip_o", mtip, 0);
    check_value("ibus_rsp_o.ready", ibus_rsp.ready, 0);
    check_value("dbus_rsp_o.ready", dbus_rsp.ready, 0);

    fd = $fopen("dv/bus_cases.txt", "r");
    if (fd == 0) report_failure("dv/bus_cases.txt could not be opened");

    while (!$feof(fd)) begin
      n = $fscanf(fd, "%s", tok);
      if (n != 1) break;
      if (tok == "#") begin
        n = $fgets(rest, fd); // Skips the rest of a comment line.
        continue;
      end
      n = $fscanf(fd, "%h %h %h %h %d", addr, wdata, wstrb, expected, check);
      if (n != 5) report_failure("a line of dv/bus_cases.txt could not be parsed");
      use_i = (tok == "i") || (tok == "b");
      use_d = (tok == "d") || (tok == "b");
      if (!use_i && !use_d) report_failure("a line of dv/bus_cases.txt has an unknown port");
      issue_request(use_i, use_d, addr, wdata, wstrb, i_data, d_data, i_at, d_at);

      if (check != 0 && use_d) check_value("dbus_rsp_o.rdata", d_data, expected);
      if (check != 0 && use_i) check_value("ibus_rsp_o.rdata", i_data, expected);
      if (use_i && use_d) check_value("data port served first", d_at < i_at, 1);

      // A data write is taken only after every earlier frame has left.
      if (use_d && addr == soc_pkg::UART_BASE + soc_pkg::UART_DATA_OFS && wstrb != 4'b0) begin
        check_value("frames sent before data write", rx_bytes.size(), tx_bytes.size());
        tx_bytes.push_back(wdata[7:0]);
      end

      if (addr == soc_pkg::CLINT_BASE + soc_pkg::CLINT_MSIP_OFS && wstrb[0]) begin
        check_value("msip_o", msip, wdata[0]);
      end

      if (addr == soc_pkg::CLINT_BASE + soc_pkg::CLINT_MTIME_OFS && wstrb == 4'b0) begin
        if (have_mtime) check_value("mtime increases", d_data > last_mtime, 1);
        last_mtime = d_data;
        have_mtime = 1'b1;
      end

      if (wstrb != 4'b0 && (addr == soc_pkg::CLINT_BASE + soc_pkg::CLINT_MTIMECMP_OFS ||
                            addr == soc_pkg::CLINT_BASE + soc_pkg::CLINT_MTIMECMP_OFS + 4)) begin
        for (int b = 0; b < 4; b++) begin
          if (wstrb[b] && addr[2] == 1'b0) cmp_shadow[8*b +: 8] = wdata[8*b +: 8];
          if (wstrb[b] && addr[2] == 1'b1) cmp_shadow[32 + 8*b +: 8] = wdata[8*b +: 8];
        end
        cnt = 0;
        do begin
          @(negedge clk);
          cnt++;
          if (cnt > MTIP_TIMEOUT) report_failure("mtip_o did not follow the new mtimecmp");
        end while (mtip !== (cmp_shadow <= cyc_since_rst));
      end
    end
    $fclose(fd);

    // **************************************************
    // Drain the UART and compare every frame.
    // **************************************************
    cnt = 0;
    while (rx_bytes.size() < tx_bytes.size()) begin
      @(negedge clk);
      cnt++;
      if (cnt > FRAME_TIMEOUT) report_failure("a UART frame never finished on tx_o");
    end
    check_value("frames on tx_o", rx_bytes.size(), tx_bytes.size());
    foreach (tx_bytes[k]) begin
      check_value("tx_o byte", rx_bytes[k], tx_bytes[k]);
    end
    ops_done = 1'b1;

    $display("TESTBENCH PASSED");
    $finish;
  end

endmodule

// File: source/bram.sv
`timescale 1ns/1ns

module bram (
  input  logic              clk,
  input  logic              rst,
  input  soc_pkg::mem_req_t req_i,
  output soc_pkg::mem_rsp_t rsp_o
);

  logic [31:0] mem [soc_pkg::BRAM_WORDS];
  logic [$clog2(soc_pkg::BRAM_WORDS)-1:0] idx;
  logic [31:0] rdata_q;
  logic        ready_q;
  logic        accept;

  assign idx = req_i.addr[$clog2(soc_pkg::BRAM_WORDS)+1:2]; // Word index.

  // The cycle that carries ready never starts a new access.
  assign accept = req_i.valid && !ready_q;

  always_ff @(posedge clk) begin
    if (accept) begin
      rdata_q <= mem[idx];
      for (int b = 0; b < 4; b++) begin
        if (req_i.wstrb[b]) begin
          mem[idx][8*b +: 8] <= req_i.wdata[8*b +: 8];
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst == 0) begin
      ready_q <= 1'b0;
    end else begin
      ready_q <= accept;
    end
  end

  assign rsp_o.rdata = rdata_q;
  assign rsp_o.ready = ready_q;

  assert property (@(posedge clk) disable iff (rst == 0) rsp_o.ready |=> !rsp_o.ready);

endmodule

// File: source/bus_router.sv
`timescale 1ns/1ns

module bus_router (
  input  logic              clk,
  input  logic              rst,
  input  soc_pkg::mem_req_t ibus_req_i,
  input  soc_pkg::mem_req_t dbus_req_i,
  output soc_pkg::mem_rsp_t ibus_rsp_o,
  output soc_pkg::mem_rsp_t dbus_rsp_o,
  output soc_pkg::mem_req_t bram_req_o,
  output soc_pkg::mem_req_t uart_req_o,
  output soc_pkg::mem_req_t clint_req_o,
  input  soc_pkg::mem_rsp_t bram_rsp_i,
  input  soc_pkg::mem_rsp_t uart_rsp_i,
  input  soc_pkg::mem_rsp_t clint_rsp_i
);

  soc_pkg::target_e  itgt;
  soc_pkg::target_e  dtgt;
  soc_pkg::mem_req_t ireq_ofs;
  soc_pkg::mem_req_t dreq_ofs;
  soc_pkg::mem_req_t tgt_req [3:1];
  soc_pkg::mem_rsp_t tgt_rsp [3:1];

  logic [3:1] sel_i;
  logic [3:1] sel_d;
  logic [3:1] grant_i;
  logic [3:1] pend_i_q;
  logic [3:1] pend_d_q;

  function automatic soc_pkg::target_e decode(input logic [31:0] addr);
    if (addr >= soc_pkg::BRAM_BASE && addr < soc_pkg::BRAM_TOP) begin
      return soc_pkg::TGT_BRAM;
    end else if (addr >= soc_pkg::UART_BASE && addr < soc_pkg::UART_TOP) begin
      return soc_pkg::TGT_UART;
    end else if (addr >= soc_pkg::CLINT_BASE && addr < soc_pkg::CLINT_TOP) begin
      return soc_pkg::TGT_CLINT;
    end
    return soc_pkg::TGT_NONE;
  endfunction

  function automatic logic [31:0] region_base(input soc_pkg::target_e tgt);
    case (tgt)
      soc_pkg::TGT_UART:  return soc_pkg::UART_BASE;
      soc_pkg::TGT_CLINT: return soc_pkg::CLINT_BASE;
      default:            return soc_pkg::BRAM_BASE;
    endcase
  endfunction

  // **************************************************
  // Decode and base subtraction.
  // **************************************************
  assign itgt = decode(ibus_req_i.addr);
  assign dtgt = decode(dbus_req_i.addr);

  always_comb begin
    ireq_ofs = ibus_req_i;
    ireq_ofs.addr = ibus_req_i.addr - region_base(itgt);
    dreq_ofs = dbus_req_i;
    dreq_ofs.addr = dbus_req_i.addr - region_base(dtgt);
  end

  assign tgt_rsp[soc_pkg::TGT_BRAM] = bram_rsp_i;
  assign tgt_rsp[soc_pkg::TGT_UART] = uart_rsp_i;
  assign tgt_rsp[soc_pkg::TGT_CLINT] = clint_rsp_i;

  // **************************************************
  // Per-target steering and pending flags.
  // **************************************************
  for (genvar t = 1; t <= 3; t++) begin : g_tgt
    assign sel_i[t] = ibus_req_i.valid && (itgt == soc_pkg::target_e'(t));
    assign sel_d[t] = dbus_req_i.valid && (dtgt == soc_pkg::target_e'(t));
    assign grant_i[t] = sel_i[t] && !sel_d[t]; // Data port wins a clash.

    always_comb begin
      tgt_req[t] = sel_d[t] ? dreq_ofs : ireq_ofs;
      tgt_req[t].valid = sel_d[t] | grant_i[t];
    end

    // A flag lives while its port holds the target and no answer has come.
    always_ff @(posedge clk) begin
      if (rst == 0) begin
        pend_i_q[t] <= 1'b0;
        pend_d_q[t] <= 1'b0;
      end else begin
        pend_i_q[t] <= grant_i[t] && !tgt_rsp[t].ready;
        pend_d_q[t] <= sel_d[t] && !tgt_rsp[t].ready;
      end
    end
  end

  assign bram_req_o = tgt_req[soc_pkg::TGT_BRAM];
  assign uart_req_o = tgt_req[soc_pkg::TGT_UART];
  assign clint_req_o = tgt_req[soc_pkg::TGT_CLINT];

  // Each answer goes back only to the port that owns the target.
  always_comb begin
    ibus_rsp_o = '0;
    dbus_rsp_o = '0;
    for (int t = 1; t <= 3; t++) begin
      if (pend_i_q[t] && tgt_rsp[t].ready) begin
        ibus_rsp_o = tgt_rsp[t];
      end
      if (pend_d_q[t] && tgt_rsp[t].ready) begin
        dbus_rsp_o = tgt_rsp[t];
      end
    end
  end

  // Unmapped addresses get no ready, so a master would hang on them.
  assert property (@(posedge clk) disable iff (rst == 0)
    ibus_req_i.valid |-> itgt != soc_pkg::TGT_NONE);
  assert property (@(posedge clk) disable iff (rst == 0)
    dbus_req_i.valid |-> dtgt != soc_pkg::TGT_NONE);
  assert property (@(posedge clk) disable iff (rst == 0) (pend_i_q & pend_d_q) == '0);

endmodule

// File: source/clint.sv
`timescale 1ns/1ns

module clint (
  input  logic              clk,
  input  logic              rst,
  input  soc_pkg::mem_req_t req_i,
  output soc_pkg::mem_rsp_t rsp_o,
  output logic              msip_o,
  output logic              mtip_o
);

  logic [63:0] mtime_q;
  logic [63:0] mtimecmp_q;
  logic [31:0] rdata_q;
  logic [31:0] rd_word;
  logic        msip_q;
  logic        mtip_q;
  logic        ready_q;
  logic        accept;

  // Merges the strobed bytes of a write into the old word.
  function automatic logic [31:0] apply_strb(input logic [31:0] old_val,
                                             input logic [31:0] new_val,
                                             input logic [3:0]  strb);
    logic [31:0] res;
    res = old_val;
    for (int b = 0; b < 4; b++) begin
      if (strb[b]) begin
        res[8*b +: 8] = new_val[8*b +: 8];
      end
    end
    return res;
  endfunction

  assign accept = req_i.valid && !ready_q;

  always_comb begin
    case (req_i.addr)
      soc_pkg::CLINT_MSIP_OFS:             rd_word = {31'b0, msip_q};
      soc_pkg::CLINT_MTIMECMP_OFS:         rd_word = mtimecmp_q[31:0];
      soc_pkg::CLINT_MTIMECMP_OFS + 32'd4: rd_word = mtimecmp_q[63:32];
      soc_pkg::CLINT_MTIME_OFS:            rd_word = mtime_q[31:0];
      soc_pkg::CLINT_MTIME_OFS + 32'd4:    rd_word = mtime_q[63:32];
      default:                             rd_word = 32'b0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst == 0) begin
      mtime_q <= 64'd0;
      mtimecmp_q <= '1; // Timer interrupt stays off until software sets a compare.
      msip_q <= 1'b0;
      mtip_q <= 1'b0;
      ready_q <= 1'b0;
    end else begin
      mtime_q <= mtime_q + 64'd1;
      mtip_q <= mtime_q >= mtimecmp_q;
      ready_q <= accept;
      if (accept && req_i.wstrb != 4'b0000) begin
        case (req_i.addr)
          soc_pkg::CLINT_MSIP_OFS: if (req_i.wstrb[0]) msip_q <= req_i.wdata[0];
          soc_pkg::CLINT_MTIMECMP_OFS:
            mtimecmp_q[31:0] <= apply_strb(mtimecmp_q[31:0], req_i.wdata, req_i.wstrb);
          soc_pkg::CLINT_MTIMECMP_OFS + 32'd4:
            mtimecmp_q[63:32] <= apply_strb(mtimecmp_q[63:32], req_i.wdata, req_i.wstrb);
          default: ;
        endcase
      end
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      rdata_q <= rd_word;
    end
  end

  assign msip_o = msip_q;
  assign mtip_o = mtip_q;
  assign rsp_o.rdata = rdata_q;
  assign rsp_o.ready = ready_q;

endmodule

// File: source/soc_bus.sv
`timescale 1ns/1ns

module soc_bus (
  input  logic              clk,
  input  logic              rst,
  input  soc_pkg::mem_req_t ibus_req_i,
  input  soc_pkg::mem_req_t dbus_req_i,
  output soc_pkg::mem_rsp_t ibus_rsp_o,
  output soc_pkg::mem_rsp_t dbus_rsp_o,
  output logic              tx_o,
  output logic              msip_o,
  output logic              mtip_o
);

  soc_pkg::mem_req_t bram_req;
  soc_pkg::mem_req_t uart_req;
  soc_pkg::mem_req_t clint_req;
  soc_pkg::mem_rsp_t bram_rsp;
  soc_pkg::mem_rsp_t uart_rsp;
  soc_pkg::mem_rsp_t clint_rsp;

  bus_router bus_router_inst (
    .clk         (clk),
    .rst         (rst),
    .ibus_req_i  (ibus_req_i),
    .dbus_req_i  (dbus_req_i),
    .ibus_rsp_o  (ibus_rsp_o),
    .dbus_rsp_o  (dbus_rsp_o),
    .bram_req_o  (bram_req),
    .uart_req_o  (uart_req),
    .clint_req_o (clint_req),
    .bram_rsp_i  (bram_rsp),
    .uart_rsp_i  (uart_rsp),
    .clint_rsp_i (clint_rsp)
  );

  bram bram_inst (.clk(clk), .rst(rst), .req_i(bram_req), .rsp_o(bram_rsp));

  uart_tx uart_tx_inst (.clk(clk), .rst(rst), .req_i(uart_req), .rsp_o(uart_rsp), .tx_o(tx_o));

  clint clint_inst (
    .clk    (clk),
    .rst    (rst),
    .req_i  (clint_req),
    .rsp_o  (clint_rsp),
    .msip_o (msip_o),
    .mtip_o (mtip_o)
  );

endmodule

// File: source/soc_pkg.sv
package soc_pkg;

  // **************************************************
  // Address map. Base is inclusive, top is exclusive.
  // **************************************************
  localparam logic [31:0] BRAM_BASE = 32'h0000_0000;
  localparam logic [31:0] BRAM_TOP = 32'h0000_0400;
  localparam logic [31:0] UART_BASE = 32'h1000_0000;
  localparam logic [31:0] UART_TOP = 32'h1000_0010;
  localparam logic [31:0] CLINT_BASE = 32'h2000_0000;
  localparam logic [31:0] CLINT_TOP = 32'h2000_C000;

  localparam int BRAM_WORDS = 256;
  localparam int UART_CLKS_PER_BIT = 4;

  // Register offsets inside each region.
  localparam logic [31:0] UART_DATA_OFS = 32'h0000_0000;
  localparam logic [31:0] UART_STATUS_OFS = 32'h0000_0004;
  localparam logic [31:0] CLINT_MSIP_OFS = 32'h0000_0000;
  localparam logic [31:0] CLINT_MTIMECMP_OFS = 32'h0000_4000; // High word at +4.
  localparam logic [31:0] CLINT_MTIME_OFS = 32'h0000_BFF8;    // High word at +4.

  // **************************************************
  // Bus types.
  // **************************************************
  typedef struct packed {
    logic        valid;
    logic        instr;  // Set on an instruction fetch.
    logic [31:0] addr;
    logic [31:0] wdata;
    logic [3:0]  wstrb;  // Zero strobes make a read.
  } mem_req_t;

  typedef struct packed {
    logic [31:0] rdata;
    logic        ready;
  } mem_rsp_t;

  typedef enum logic [1:0] {TGT_NONE, TGT_BRAM, TGT_UART, TGT_CLINT} target_e;

  typedef enum logic [1:0] {UART_IDLE, UART_START, UART_DATA, UART_STOP} uart_state_e;

endpackage

// File: source/uart_tx.sv
`timescale 1ns/1ns

module uart_tx (
  input  logic              clk,
  input  logic              rst,
  input  soc_pkg::mem_req_t req_i,
  output soc_pkg::mem_rsp_t rsp_o,
  output logic              tx_o
);

  soc_pkg::uart_state_e state_q;
  logic [$clog2(soc_pkg::UART_CLKS_PER_BIT)-1:0] clk_cnt_q;
  logic [2:0]  bit_idx_q;
  logic [7:0]  shift_q;
  logic [31:0] rdata_q;
  logic        ready_q;
  logic        tx_q;
  logic        busy;
  logic        bit_end;
  logic        data_wr;
  logic        accept;
  logic        start;

  assign busy = state_q != soc_pkg::UART_IDLE;
  assign bit_end = clk_cnt_q == ($bits(clk_cnt_q))'(soc_pkg::UART_CLKS_PER_BIT - 1);
  assign data_wr = (req_i.addr == soc_pkg::UART_DATA_OFS) && (req_i.wstrb != 4'b0000);
  assign accept = req_i.valid && !ready_q && !(data_wr && busy); // Busy writes wait.
  assign start = accept && data_wr;

  // **************************************************
  // Frame FSM that sends a start bit, eight data bits and a stop bit.
  // **************************************************
  always_ff @(posedge clk) begin
    if (rst == 0) begin
      state_q <= soc_pkg::UART_IDLE;
      clk_cnt_q <= '0;
      bit_idx_q <= 3'd0;
      tx_q <= 1'b1;
      ready_q <= 1'b0;
    end else begin
      ready_q <= accept;
      clk_cnt_q <= (!busy || bit_end) ? '0 : clk_cnt_q + 1'b1;
      case (state_q)
        soc_pkg::UART_IDLE: if (start) begin
          state_q <= soc_pkg::UART_START;
          tx_q <= 1'b0;
        end
        soc_pkg::UART_START: if (bit_end) begin
          state_q <= soc_pkg::UART_DATA;
          bit_idx_q <= 3'd0;
          tx_q <= shift_q[0]; // LSB goes first.
        end
        soc_pkg::UART_DATA: if (bit_end) begin
          if (bit_idx_q == 3'd7) begin
            state_q <= soc_pkg::UART_STOP;
            tx_q <= 1'b1;
          end else begin
            bit_idx_q <= bit_idx_q + 3'd1;
            tx_q <= shift_q[1];
          end
        end
        soc_pkg::UART_STOP: if (bit_end) begin
          state_q <= soc_pkg::UART_IDLE;
        end
        default: state_q <= soc_pkg::UART_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (start) begin
      shift_q <= req_i.wdata[7:0];
    end else if (state_q == soc_pkg::UART_DATA && bit_end) begin
      shift_q <= shift_q >> 1;
    end
    if (accept) begin
      rdata_q <= (req_i.addr == soc_pkg::UART_STATUS_OFS) ? {31'b0, busy} : 32'b0;
    end
  end

  assign tx_o = tx_q;
  assign rsp_o.rdata = rdata_q;
  assign rsp_o.ready = ready_q;

  assert property (@(posedge clk) disable iff (rst == 0)
    (state_q == soc_pkg::UART_IDLE) |-> tx_o);

endmodule

// File: src.f
source/soc_pkg.sv
source/bus_router.sv
source/bram.sv
source/uart_tx.sv
source/clint.sv
source/soc_bus.sv
dv/soc_bus_tb.sv
